// File: tb/plot_input.txt
# s frame adc_x adc_y red grn blu   (adc values in hex, one strobe each)
# e frame screen_x screen_y color   (colour as 12-bit hex rgb, others black)
s 0 14 08 1 1 1
s 0 3c 2c 1 0 0
s 0 20 34 0 1 0
e 0 5 2 fff
e 0 15 11 f00
s 1 00 00 0 0 1
e 1 0 0 00f
s 2 3f 3f 1 1 1
s 2 08 1c 0 1 1
e 2 2 7 0ff
e 4 5 2 bbb
s 5 15 0a 1 1 1
e 5 5 2 fff
e 14 15 11 100
e 16 0 0 000
e 17 5 2 333
e 17 15 11 000
e 17 2 7 000

// File: adc_xy_vga_fade.f
+incdir+hdl
hdl/xy_plot_pkg.sv
hdl/adc_xy_capture.sv
hdl/fb_clear.sv
hdl/plot_source_mux.sv
hdl/vga_timing.sv
hdl/fb_fade_display.sv
hdl/adc_xy_vga_fade.sv
tb/adc_xy_vga_fade_sva.sv
tb/adc_xy_vga_fade_tb.sv

// File: Bender.yml
package:
  name: adc_xy_vga_fade

export_include_dirs:
  - hdl

sources:
  - files:
      - hdl/xy_plot_pkg.sv
      - hdl/adc_xy_capture.sv
      - hdl/fb_clear.sv
      - hdl/plot_source_mux.sv
      - hdl/vga_timing.sv
      - hdl/fb_fade_display.sv
      - hdl/adc_xy_vga_fade.sv
  - target: test
    files:
      - tb/adc_xy_vga_fade_sva.sv
      - tb/adc_xy_vga_fade_tb.sv

// File: tb/adc_xy_vga_fade_tb.sv
`timescale 1ns/10ps

`include "xy_plot_settings.svh"

module adc_xy_vga_fade_tb;

  localparam int LINE     = `XY_H_WHOLE_LINE;
  localparam int FRAME    = `XY_H_WHOLE_LINE * `XY_V_WHOLE_FRAME;
  localparam int HS_START = `XY_H_VISIBLE + `XY_H_FRONT_PORCH;
  localparam int HS_END   = HS_START + `XY_H_SYNC_PULSE;
  // clear sweep plus settling, sync must stay low this long
  localparam int QUIET    = `XY_H_VISIBLE * `XY_V_VISIBLE + `XY_START_DELAY;

  // late sample, adc (3c,04) green only, lands on screen (15,1)
  localparam logic [`XY_ADC_BITS-1:0] LATE_ADC_X = 6'h3c;
  localparam logic [`XY_ADC_BITS-1:0] LATE_ADC_Y = 6'h04;
  localparam int                      LATE_COL   = 15;
  localparam int                      LATE_ROW   = 1;
  localparam logic [11:0]             LATE_COLOR = 12'h0f0;

  logic                      clk = 1'b0;
  logic                      reset;
  logic                      adc_strobe;
  logic [`XY_ADC_BITS-1:0]   adc_x;
  logic [`XY_ADC_BITS-1:0]   adc_y;
  logic                      adc_red;
  logic                      adc_grn;
  logic                      adc_blu;
  logic [`XY_COLOR_BITS-1:0] vga_red;
  logic [`XY_COLOR_BITS-1:0] vga_grn;
  logic [`XY_COLOR_BITS-1:0] vga_blu;
  logic                      vga_hsync;
  logic                      vga_vsync;
  xy_plot_pkg::rgb_t         shown;

  xy_plot_pkg::adc_sample_t  smp_q[$];
  int                        smp_frame[$];
  xy_plot_pkg::plot_pixel_t  exp_q[$];
  int                        exp_frame[$];
  // expected picture of the coming frame
  xy_plot_pkg::rgb_t         img [`XY_V_VISIBLE][`XY_H_VISIBLE];
  int                        cyc = 0;

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  assign shown = '{red: vga_red, grn: vga_grn, blu: vga_blu};

  adc_xy_vga_fade i_adc_xy_vga_fade (
    .clk        (clk),
    .reset      (reset),
    .adc_strobe (adc_strobe),
    .adc_x      (adc_x),
    .adc_y      (adc_y),
    .adc_red    (adc_red),
    .adc_grn    (adc_grn),
    .adc_blu    (adc_blu),
    .vga_red    (vga_red),
    .vga_grn    (vga_grn),
    .vga_blu    (vga_blu),
    .vga_hsync  (vga_hsync),
    .vga_vsync  (vga_vsync)
  );

  task automatic abort(input string what);
    $display("%s", what);
    $display("Checks failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      abort($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
    end
  endtask

  always @(negedge clk) begin
    if (i_adc_xy_vga_fade.i_sva.fired != 0) begin
      abort("a bound assertion on the DUT fired");
    end
  end

  // one fade step per channel, floor at zero
  function automatic xy_plot_pkg::rgb_t aged(input xy_plot_pkg::rgb_t c);
    aged.red = (c.red > 0) ? c.red - 1'b1 : '0;
    aged.grn = (c.grn > 0) ? c.grn - 1'b1 : '0;
    aged.blu = (c.blu > 0) ? c.blu - 1'b1 : '0;
  endfunction

  // blank cycles until vsync reaches the level
  task automatic wait_vsync(input logic level, input int limit, input int quiet);
    int n;
    n = 0;
    while (vga_vsync !== level) begin
      check("vga_color", shown, 0);
      if (n < quiet) begin
        check("vga_hsync", vga_hsync, 1'b0);
      end
      @(negedge clk);
      n++;
      if (n > limit) begin
        abort($sformatf("timeout waiting for vga_vsync to become %0b", level));
      end
    end
  endtask

  task automatic strobe(input xy_plot_pkg::adc_sample_t s);
    adc_strobe = 1'b1;
    adc_x      = s.x;
    adc_y      = s.y;
    adc_red    = s.red;
    adc_grn    = s.grn;
    adc_blu    = s.blu;
    @(negedge clk);
    adc_strobe = 1'b0;
    adc_x      = '0;
    adc_y      = '0;
    repeat (3) @(negedge clk);
  endtask

  // starts at line 0 pixel 0, ends at the first blank line
  task automatic scan_frame();
    for (int v = 0; v < `XY_V_VISIBLE; v++) begin
      for (int h = 0; h < LINE; h++) begin
        if (h < `XY_H_VISIBLE) begin
          check($sformatf("vga_color at %0d,%0d", h, v), shown, img[v][h]);
        end else begin
          check("vga_color in hblank", shown, 0);
        end
        check("vga_hsync", vga_hsync, h >= HS_START && h < HS_END);
        check("vga_vsync", vga_vsync, 1'b0);
        @(negedge clk);
      end
    end
  endtask

  initial begin
    int    fd;
    int    n;
    int    f;
    int    a;
    int    b;
    int    r;
    int    g;
    int    bl;
    int    last_frame;
    int    rise_cyc;
    string line;
    reset      = 1'b1;
    adc_strobe = 1'b0;
    adc_x      = '0;
    adc_y      = '0;
    adc_red    = 1'b0;
    adc_grn    = 1'b0;
    adc_blu    = 1'b0;
    last_frame = 0;
    rise_cyc   = 0;
    foreach (img[y, x]) img[y][x] = '0;

    fd = $fopen("tb/plot_input.txt", "r");
    if (fd == 0) begin
      abort("cannot open tb/plot_input.txt");
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 3 || line[0] == "#") begin
        continue;
      end
      if (line[0] == "s") begin
        n = $sscanf(line.substr(2, line.len() - 1), "%d %h %h %h %h %h", f, a, b, r, g, bl);
        if (n != 6) abort($sformatf("bad sample line: %s", line));
        smp_frame.push_back(f);
        smp_q.push_back('{
          x:   a[`XY_ADC_BITS-1:0],
          y:   b[`XY_ADC_BITS-1:0],
          red: r[0],
          grn: g[0],
          blu: bl[0]
        });
      end else if (line[0] == "e") begin
        n = $sscanf(line.substr(2, line.len() - 1), "%d %d %d %h", f, a, b, r);
        if (n != 4) abort($sformatf("bad expect line: %s", line));
        exp_frame.push_back(f);
        exp_q.push_back('{
          x:     a[`XY_FB_X_BITS-1:0],
          y:     b[`XY_FB_Y_BITS-1:0],
          color: r[11:0]
        });
      end else begin
        abort($sformatf("unknown line kind: %s", line));
      end
      if (f > last_frame) last_frame = f;
    end
    $fclose(fd);

    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // first enabled frame shows the cleared framebuffer
    wait_vsync(1'b1, 2 * FRAME, QUIET);
    for (int fr = 0; fr <= last_frame; fr++) begin
      if (fr > 0) begin
        wait_vsync(1'b1, FRAME, 0);
        check("vga_vsync period", cyc - rise_cyc, FRAME);
      end
      rise_cyc = cyc;
      for (int i = 0; i < smp_q.size(); i++) begin
        if (smp_frame[i] == fr) strobe(smp_q[i]);
      end
      wait_vsync(1'b0, FRAME, 0);
      check("vga_vsync width", cyc - rise_cyc, `XY_V_SYNC_PULSE * LINE);
      if (fr > 0) begin
        foreach (img[y, x]) img[y][x] = aged(img[y][x]);
      end
      for (int i = 0; i < exp_q.size(); i++) begin
        if (exp_frame[i] == fr) img[exp_q[i].y][exp_q[i].x] = exp_q[i].color;
      end
      // rest of the last blank line
      for (int h = 1; h < LINE; h++) begin
        @(negedge clk);
        check("vga_color in vblank", shown, 0);
        adc_strobe = 1'b0;
        if (fr == 0 && h == LINE - 3) begin
          // taken at the line end, waits out the visible part of line 0
          adc_strobe = 1'b1;
          adc_x      = LATE_ADC_X;
          adc_y      = LATE_ADC_Y;
          adc_red    = 1'b0;
          adc_grn    = 1'b1;
          adc_blu    = 1'b0;
          img[LATE_ROW][LATE_COL] = LATE_COLOR;
        end
      end
      @(negedge clk);
      adc_strobe = 1'b0;
      scan_frame();
    end
    $display("All checks passed");
    $finish;
  end

endmodule

// File: tb/adc_xy_vga_fade_sva.sv
`timescale 1ns/10ps

`include "xy_plot_settings.svh"

module adc_xy_vga_fade_sva (
  input logic                      clk,
  input logic                      reset,
  input logic                      pix_valid,
  input logic                      pix_ready,
  input xy_plot_pkg::plot_pixel_t  pix,
  input xy_plot_pkg::rgb_t         color,
  input logic                      vga_hsync,
  input logic                      vga_vsync
);

  int fired = 0;

  // a stalled pixel waits unchanged
  stall_stable: assert property (@(posedge clk) disable iff (reset)
    pix_valid && !pix_ready |=> pix_valid && $stable(pix))
    else begin
      fired++;
      $error("plot pixel changed while stalled");
    end

  sync_black: assert property (@(posedge clk) disable iff (reset)
    (vga_hsync || vga_vsync) |-> color == '0)
    else begin
      fired++;
      $error("colour not zero during sync");
    end

  hsync_width: assert property (@(posedge clk) disable iff (reset)
    $rose(vga_hsync) |-> vga_hsync [*`XY_H_SYNC_PULSE] ##1 !vga_hsync)
    else begin
      fired++;
      $error("hsync pulse has the wrong width");
    end

endmodule

bind adc_xy_vga_fade adc_xy_vga_fade_sva i_sva (
  .clk       (clk),
  .reset     (reset),
  .pix_valid (pix_valid),
  .pix_ready (pix_ready),
  .pix       (pix),
  .color     (color),
  .vga_hsync (vga_hsync),
  .vga_vsync (vga_vsync)
);

// File: hdl/adc_xy_vga_fade.sv
`timescale 1ns/10ps

`include "xy_plot_settings.svh"

module adc_xy_vga_fade (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       adc_strobe,
  input  logic [`XY_ADC_BITS-1:0]    adc_x,
  input  logic [`XY_ADC_BITS-1:0]    adc_y,
  input  logic                       adc_red,
  input  logic                       adc_grn,
  input  logic                       adc_blu,
  output logic [`XY_COLOR_BITS-1:0]  vga_red,
  output logic [`XY_COLOR_BITS-1:0]  vga_grn,
  output logic [`XY_COLOR_BITS-1:0]  vga_blu,
  output logic                       vga_hsync,
  output logic                       vga_vsync
);

  localparam int H_BITS = $clog2(`XY_H_WHOLE_LINE);
  localparam int V_BITS = $clog2(`XY_V_WHOLE_FRAME);

  logic                      sample_valid;
  logic                      sample_take;
  xy_plot_pkg::adc_sample_t  sample;

  logic                      clr_valid;
  logic                      clr_ready;
  logic                      clr_last;
  xy_plot_pkg::plot_pixel_t  clr_pix;

  logic                      pix_valid;
  logic                      pix_ready;
  xy_plot_pkg::plot_pixel_t  pix;
  logic                      enable;

  logic [H_BITS-1:0]         h_count;
  logic [V_BITS-1:0]         v_count;
  logic                      visible;
  xy_plot_pkg::rgb_t         color;

  adc_xy_capture i_capture (
    .clk          (clk),
    .reset        (reset),
    .adc_strobe   (adc_strobe),
    .adc_x        (adc_x),
    .adc_y        (adc_y),
    .adc_red      (adc_red),
    .adc_grn      (adc_grn),
    .adc_blu      (adc_blu),
    .sample_take  (sample_take),
    .sample_valid (sample_valid),
    .sample       (sample)
  );

  fb_clear i_clear (
    .clk       (clk),
    .reset     (reset),
    .pix_ready (clr_ready),
    .pix_valid (clr_valid),
    .pix       (clr_pix),
    .last      (clr_last)
  );

  plot_source_mux i_mux (
    .clk          (clk),
    .reset        (reset),
    .clr_valid    (clr_valid),
    .clr_pix      (clr_pix),
    .clr_last     (clr_last),
    .clr_ready    (clr_ready),
    .sample_valid (sample_valid),
    .sample       (sample),
    .sample_take  (sample_take),
    .pix_ready    (pix_ready),
    .pix_valid    (pix_valid),
    .pix          (pix),
    .enable       (enable)
  );

  vga_timing #(
    .H_BITS (H_BITS),
    .V_BITS (V_BITS)
  ) i_timing (
    .clk     (clk),
    .reset   (reset),
    .enable  (enable),
    .h_count (h_count),
    .v_count (v_count),
    .visible (visible),
    .hsync   (vga_hsync),
    .vsync   (vga_vsync)
  );

  fb_fade_display #(
    .H_BITS (H_BITS),
    .V_BITS (V_BITS)
  ) i_display (
    .clk       (clk),
    .reset     (reset),
    .enable    (enable),
    .h_count   (h_count),
    .v_count   (v_count),
    .visible   (visible),
    .pix_valid (pix_valid),
    .pix       (pix),
    .pix_ready (pix_ready),
    .color     (color)
  );

  // colour pins
  assign vga_red = color.red;
  assign vga_grn = color.grn;
  assign vga_blu = color.blu;

endmodule

// File: hdl/fb_fade_display.sv
`timescale 1ns/10ps

`include "xy_plot_settings.svh"

module fb_fade_display #(
  parameter int H_BITS = $clog2(`XY_H_WHOLE_LINE),
  parameter int V_BITS = $clog2(`XY_V_WHOLE_FRAME)
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      enable,
  input  logic [H_BITS-1:0]         h_count,
  input  logic [V_BITS-1:0]         v_count,
  input  logic                      visible,
  input  logic                      pix_valid,
  input  xy_plot_pkg::plot_pixel_t  pix,
  output logic                      pix_ready,
  output xy_plot_pkg::rgb_t         color
);

  xy_plot_pkg::rgb_t fb [`XY_V_VISIBLE][`XY_H_VISIBLE];

  logic                     scan_active;
  logic [`XY_FB_X_BITS-1:0] scan_x;
  logic [`XY_FB_Y_BITS-1:0] scan_y;
  xy_plot_pkg::rgb_t        scan_rd;
  xy_plot_pkg::rgb_t        faded;

  // one step down, stuck at zero
  function automatic logic [`XY_COLOR_BITS-1:0] dim(input logic [`XY_COLOR_BITS-1:0] c);
    dim = (c == '0) ? c : c - 1'b1;
  endfunction

  assign scan_active = enable && visible;

  // the write port is busy with fade write-back during visible scan
  assign pix_ready = !scan_active;

  assign scan_x  = h_count[`XY_FB_X_BITS-1:0];
  assign scan_y  = v_count[`XY_FB_Y_BITS-1:0];
  assign scan_rd = fb[scan_y][scan_x];

  assign faded = '{
    red: dim(scan_rd.red),
    grn: dim(scan_rd.grn),
    blu: dim(scan_rd.blu)
  };

  always_ff @(posedge clk) begin
    if (scan_active) begin
      fb[scan_y][scan_x] <= faded;
    end else if (pix_valid) begin
      fb[pix.y][pix.x] <= pix.color;
    end
  end

  // shown value is the one before this frame's fade
  always_ff @(posedge clk) begin
    if (reset) begin
      color <= '0;
    end else if (scan_active) begin
      color <= scan_rd;
    end else begin
      color <= '0;
    end
  end

endmodule

// File: hdl/vga_timing.sv
`timescale 1ns/10ps

`include "xy_plot_settings.svh"

module vga_timing #(
  parameter int H_BITS = $clog2(`XY_H_WHOLE_LINE),
  parameter int V_BITS = $clog2(`XY_V_WHOLE_FRAME)
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              enable,
  output logic [H_BITS-1:0] h_count,
  output logic [V_BITS-1:0] v_count,
  output logic              visible,
  output logic              hsync,
  output logic              vsync
);

  localparam int H_SYNC_START = `XY_H_VISIBLE + `XY_H_FRONT_PORCH;
  localparam int H_SYNC_END   = H_SYNC_START + `XY_H_SYNC_PULSE;
  localparam int V_SYNC_START = `XY_V_VISIBLE + `XY_V_FRONT_PORCH;
  localparam int V_SYNC_END   = V_SYNC_START + `XY_V_SYNC_PULSE;

  logic line_end;
  logic frame_end;
  logic h_in_sync;
  logic v_in_sync;

  assign line_end  = h_count == H_BITS'(`XY_H_WHOLE_LINE - 1);
  assign frame_end = v_count == V_BITS'(`XY_V_WHOLE_FRAME - 1);

  // scan stays parked at line 0, pixel 0 until start
  always_ff @(posedge clk) begin
    if (reset || !enable) begin
      h_count <= '0;
      v_count <= '0;
    end else if (line_end) begin
      h_count <= '0;
      v_count <= frame_end ? '0 : v_count + 1'b1;
    end else begin
      h_count <= h_count + 1'b1;
    end
  end

  assign visible = (h_count < H_BITS'(`XY_H_VISIBLE)) &&
                   (v_count < V_BITS'(`XY_V_VISIBLE));

  assign h_in_sync = (h_count >= H_BITS'(H_SYNC_START)) &&
                     (h_count < H_BITS'(H_SYNC_END));
  assign v_in_sync = (v_count >= V_BITS'(V_SYNC_START)) &&
                     (v_count < V_BITS'(V_SYNC_END));

  // one cycle behind the counters, in step with the colour register
  always_ff @(posedge clk) begin
    if (reset) begin
      hsync <= 1'b0;
      vsync <= 1'b0;
    end else begin
      hsync <= enable && h_in_sync;
      vsync <= enable && v_in_sync;
    end
  end

endmodule

// File: hdl/plot_source_mux.sv
`timescale 1ns/10ps

`include "xy_plot_settings.svh"

module plot_source_mux (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      clr_valid,
  input  xy_plot_pkg::plot_pixel_t  clr_pix,
  input  logic                      clr_last,
  output logic                      clr_ready,
  input  logic                      sample_valid,
  input  xy_plot_pkg::adc_sample_t  sample,
  output logic                      sample_take,
  input  logic                      pix_ready,
  output logic                      pix_valid,
  output xy_plot_pkg::plot_pixel_t  pix,
  output logic                      enable
);

  localparam int DELAY_BITS = $clog2(`XY_START_DELAY + 1);

  logic [DELAY_BITS-1:0]         delay_cnt;
  logic                          delay_run;
  logic [`XY_ADC_BITS-1:0]       scaled_x;
  logic [`XY_ADC_BITS-1:0]       scaled_y;
  logic                          in_range;
  logic                          adc_free;
  logic                          adc_valid;
  xy_plot_pkg::plot_pixel_t      adc_pix;

  // start sequence, counted from the last clear transfer
  always_ff @(posedge clk) begin
    if (reset) begin
      delay_run <= 1'b0;
      delay_cnt <= '0;
      enable    <= 1'b0;
    end else if (clr_valid && clr_ready && clr_last) begin
      delay_run <= 1'b1;
      delay_cnt <= DELAY_BITS'(1);
    end else if (delay_run) begin
      if (delay_cnt == DELAY_BITS'(`XY_START_DELAY - 1)) begin
        delay_run <= 1'b0;
        enable    <= 1'b1;
      end else begin
        delay_cnt <= delay_cnt + 1'b1;
      end
    end
  end

  assign scaled_x = sample.x >> `XY_ADC_SHIFT;
  assign scaled_y = sample.y >> `XY_ADC_SHIFT;
  assign in_range = scaled_y < `XY_ADC_BITS'(`XY_V_VISIBLE);

  // output register empty or draining this cycle
  assign adc_free    = !adc_valid || pix_ready;
  assign sample_take = enable && sample_valid && adc_free;

  always_ff @(posedge clk) begin
    if (reset) begin
      adc_valid <= 1'b0;
    end else if (adc_free) begin
      // out of range samples are taken and vanish here
      adc_valid <= sample_take && in_range;
    end
  end

  always_ff @(posedge clk) begin
    if (sample_take) begin
      adc_pix <= '{
        x:     scaled_x[`XY_FB_X_BITS-1:0],
        y:     scaled_y[`XY_FB_Y_BITS-1:0],
        color: '{
          red: {`XY_COLOR_BITS{sample.red}},
          grn: {`XY_COLOR_BITS{sample.grn}},
          blu: {`XY_COLOR_BITS{sample.blu}}
        }
      };
    end
  end

  assign clr_ready = !enable && pix_ready;
  assign pix_valid = enable ? adc_valid : clr_valid;
  assign pix       = enable ? adc_pix : clr_pix;

endmodule

// File: hdl/fb_clear.sv
`timescale 1ns/10ps

`include "xy_plot_settings.svh"

module fb_clear (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      pix_ready,
  output logic                      pix_valid,
  output xy_plot_pkg::plot_pixel_t  pix,
  output logic                      last
);

  localparam logic [`XY_FB_X_BITS-1:0] X_MAX = `XY_FB_X_BITS'(`XY_H_VISIBLE - 1);
  localparam logic [`XY_FB_Y_BITS-1:0] Y_MAX = `XY_FB_Y_BITS'(`XY_V_VISIBLE - 1);

  logic [`XY_FB_X_BITS-1:0] cur_x;
  logic [`XY_FB_Y_BITS-1:0] cur_y;
  logic                     done;
  logic                     xfer;

  assign xfer = pix_valid && pix_ready;
  assign last = (cur_x == X_MAX) && (cur_y == Y_MAX);

  // black at the current coordinate
  assign pix = '{x: cur_x, y: cur_y, color: '0};

  always_ff @(posedge clk) begin
    if (reset) begin
      pix_valid <= 1'b0;
      done      <= 1'b0;
      cur_x     <= '0;
      cur_y     <= '0;
    end else if (!pix_valid && !done) begin
      pix_valid <= 1'b1;
    end else if (xfer) begin
      if (last) begin
        // sweep is over for good
        pix_valid <= 1'b0;
        done      <= 1'b1;
      end else if (cur_x == X_MAX) begin
        cur_x <= '0;
        cur_y <= cur_y + 1'b1;
      end else begin
        cur_x <= cur_x + 1'b1;
      end
    end
  end

endmodule

// File: hdl/adc_xy_capture.sv
`timescale 1ns/10ps

`include "xy_plot_settings.svh"

module adc_xy_capture (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        adc_strobe,
  input  logic [`XY_ADC_BITS-1:0]     adc_x,
  input  logic [`XY_ADC_BITS-1:0]     adc_y,
  input  logic                        adc_red,
  input  logic                        adc_grn,
  input  logic                        adc_blu,
  input  logic                        sample_take,
  output logic                        sample_valid,
  output xy_plot_pkg::adc_sample_t    sample
);

  logic capture;

  // new samples only land in an empty holding register
  assign capture = adc_strobe && !sample_valid;

  always_ff @(posedge clk) begin
    if (reset) begin
      sample_valid <= 1'b0;
    end else if (sample_valid && sample_take) begin
      sample_valid <= 1'b0;
    end else if (capture) begin
      sample_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      sample <= '{
        x:   adc_x,
        y:   adc_y,
        red: adc_red,
        grn: adc_grn,
        blu: adc_blu
      };
    end
  end

endmodule

// File: hdl/xy_plot_pkg.sv
`include "xy_plot_settings.svh"

package xy_plot_pkg;

  // one framebuffer pixel, 12 bits
  typedef struct packed {
    logic [`XY_COLOR_BITS-1:0] red;
    logic [`XY_COLOR_BITS-1:0] grn;
    logic [`XY_COLOR_BITS-1:0] blu;
  } rgb_t;

  // raw adc pins as captured
  typedef struct packed {
    logic [`XY_ADC_BITS-1:0] x;
    logic [`XY_ADC_BITS-1:0] y;
    logic                    red;
    logic                    grn;
    logic                    blu;
  } adc_sample_t;

  // pixel write toward the framebuffer
  typedef struct packed {
    logic [`XY_FB_X_BITS-1:0] x;
    logic [`XY_FB_Y_BITS-1:0] y;
    rgb_t                     color;
  } plot_pixel_t;

endpackage

// File: hdl/xy_plot_settings.svh
`ifndef XY_PLOT_SETTINGS_SVH
`define XY_PLOT_SETTINGS_SVH

// adc channel width
`define XY_ADC_BITS 6

// bits per colour channel
`define XY_COLOR_BITS 4

// reduced vga mode, horizontal in pixels
`define XY_H_VISIBLE 16
`define XY_H_FRONT_PORCH 2
`define XY_H_SYNC_PULSE 3
`define XY_H_BACK_PORCH 3
`define XY_H_WHOLE_LINE 24

// vertical in lines
`define XY_V_VISIBLE 12
`define XY_V_FRONT_PORCH 1
`define XY_V_SYNC_PULSE 2
`define XY_V_BACK_PORCH 1
`define XY_V_WHOLE_FRAME 16

// framebuffer coordinates
`define XY_FB_X_BITS 4
`define XY_FB_Y_BITS 4

// adc range down to screen range
`define XY_ADC_SHIFT 2

// settling cycles after the clear sweep
`define XY_START_DELAY 8

`endif
